/* Bender.yml */
package:
  name: issue_stage

sources:
  - src/isa_pkg.sv
  - src/issue_pkg.sv
  - src/issue_queue.sv
  - src/pair_check.sv
  - src/operand_select.sv
  - src/reg_file.sv
  - src/issue_top.sv
  - target: simulation
    files:
      - sim/tb_issue_top.sv

/* files.f */
src/isa_pkg.sv
src/issue_pkg.sv
src/issue_queue.sv
src/pair_check.sv
src/operand_select.sv
src/reg_file.sv
src/issue_top.sv
sim/tb_issue_top.sv

/* sim/tb_issue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_issue_top
    import isa_pkg::*;
    import issue_pkg::*;
();

    typedef struct packed {
        word_t pc;
        op_t   op;
        reg_t  rdst;
        reg_t  ra1;
        reg_t  ra2;
        word_t imm;
    } instr_t;

    logic  clk;
    logic  rst_n;
    logic  stall;
    logic  flush;
    logic  dec_valid  [2];
    word_t dec_pc     [2];
    op_t   dec_op     [2];
    reg_t  dec_rdst   [2];
    reg_t  dec_ra1    [2];
    reg_t  dec_ra2    [2];
    word_t dec_imm    [2];
    logic  wb_we      [2];
    reg_t  wb_addr    [2];
    word_t wb_data    [2];
    logic  iss_valid  [2];
    word_t iss_pc     [2];
    op_t   iss_op     [2];
    reg_t  iss_rdst   [2];
    word_t iss_rs_val [2];
    word_t iss_rt_val [2];
    word_t iss_imm    [2];
    logic  iss_slot   [2];
    logic  overflow;

    word_t  model_regs [32];
    instr_t exp_q [$];
    word_t  next_pc;
    integer seed;
    int     errors;
    int     pass_count;
    int     fail_count;

    issue_top uut (
        .clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
        .dec_valid(dec_valid), .dec_pc(dec_pc), .dec_op(dec_op), .dec_rdst(dec_rdst),
        .dec_ra1(dec_ra1), .dec_ra2(dec_ra2), .dec_imm(dec_imm),
        .wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
        .iss_valid(iss_valid), .iss_pc(iss_pc), .iss_op(iss_op), .iss_rdst(iss_rdst),
        .iss_rs_val(iss_rs_val), .iss_rt_val(iss_rt_val), .iss_imm(iss_imm),
        .iss_slot(iss_slot), .overflow(overflow)
    );

    always #10 clk = ~clk;

    // {branch, writes reg, mul/div, writes hi/lo, reads hi/lo}
    function automatic logic [4:0] op_flags(input op_t op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_LUI: return 5'b01000;
            OP_BEQ, OP_BNE, OP_J:                  return 5'b10000;
            OP_JAL:                                return 5'b11000;
            OP_MULT, OP_DIV:                       return 5'b00110;
            OP_MTHI, OP_MTLO:                      return 5'b00010;
            OP_MFHI, OP_MFLO:                      return 5'b01001;
            default:                               return 5'b00000;
        endcase
    endfunction

    // register value as seen this cycle, later writeback lane wins
    function automatic word_t expect_operand(input reg_t ra);
        word_t v;
        v = model_regs[ra];
        if (wb_we[0] && wb_addr[0] == ra) v = wb_data[0];
        if (wb_we[1] && wb_addr[1] == ra) v = wb_data[1];
        if (ra == '0) v = '0;
        return v;
    endfunction

    function automatic instr_t mk(input op_t op, input reg_t rdst, input reg_t ra1,
                                 input reg_t ra2);
        instr_t ins;
        ins = {next_pc, op, rdst, ra1, ra2, next_pc ^ 32'h0000_5a5a};
        next_pc = next_pc + 32'd4;
        return ins;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("[ERROR] %s: expected %h, got %h", name, exp, got);
        errors++;
    endtask

    // one cycle of the reference model, sampled between the edges
    task automatic model_cycle();
        instr_t     pend [$];
        instr_t     cur;
        logic [4:0] f0;
        logic [4:0] f1;
        logic       v0;
        logic       v1;
        logic       ok1;
        logic       ovf;
        logic       en [2];
        pend = exp_q;
        ovf = exp_q.size() > QUEUE_DEPTH - 3;
        if (overflow !== ovf) report_mismatch("overflow", 32'(ovf), 32'(overflow));
        if (!flush && !ovf) begin
            for (int i = 0; i < 2; i++) begin
                if (dec_valid[i]) begin
                    pend.push_back({dec_pc[i], dec_op[i], dec_rdst[i],
                                    dec_ra1[i], dec_ra2[i], dec_imm[i]});
                end
            end
        end
        v0 = !flush && pend.size() > 0;
        v1 = !flush && pend.size() > 1;
        f0 = v0 ? op_flags(pend[0].op) : 5'b0;
        f1 = v1 ? op_flags(pend[1].op) : 5'b0;
        ok1 = v1 && !f1[4] && !(f0[2] && f1[2]) && !(f0[1] && f1[0]);
        if (v1 && f0[3] && !f0[4] && pend[0].rdst != '0 &&
            (pend[0].rdst == pend[1].ra1 || pend[0].rdst == pend[1].ra2)) begin
            ok1 = 1'b0;
        end
        en[0] = v0 && !stall && (!f0[4] || ok1);
        en[1] = en[0] && ok1;
        for (int i = 0; i < 2; i++) begin
            if (iss_valid[i] !== en[i])
                report_mismatch($sformatf("iss_valid[%0d]", i), 32'(en[i]), 32'(iss_valid[i]));
            if (en[i]) begin
                cur = pend[i];
                if (iss_pc[i] !== cur.pc)
                    report_mismatch($sformatf("iss_pc[%0d]", i), cur.pc, iss_pc[i]);
                if (iss_op[i] !== cur.op)
                    report_mismatch($sformatf("iss_op[%0d]", i), 32'(cur.op), 32'(iss_op[i]));
                if (iss_rdst[i] !== cur.rdst)
                    report_mismatch($sformatf("iss_rdst[%0d]", i), 32'(cur.rdst),
                                    32'(iss_rdst[i]));
                if (iss_imm[i] !== cur.imm)
                    report_mismatch($sformatf("iss_imm[%0d]", i), cur.imm, iss_imm[i]);
                if (iss_rs_val[i] !== expect_operand(cur.ra1))
                    report_mismatch($sformatf("iss_rs_val[%0d]", i),
                                    expect_operand(cur.ra1), iss_rs_val[i]);
                if (iss_rt_val[i] !== expect_operand(cur.ra2))
                    report_mismatch($sformatf("iss_rt_val[%0d]", i),
                                    expect_operand(cur.ra2), iss_rt_val[i]);
            end
        end
        // the older lane is never a delay slot
        if (en[0] && iss_slot[0] !== 1'b0)
            report_mismatch("iss_slot[0]", 32'h0, 32'(iss_slot[0]));
        if (en[1] && iss_slot[1] !== f0[4])
            report_mismatch("iss_slot[1]", 32'(f0[4]), 32'(iss_slot[1]));
        if (en[0]) pend.delete(0);
        if (en[1]) pend.delete(0);
        if (flush) exp_q.delete();
        else exp_q = pend;
        // writes land at the coming edge
        for (int p = 0; p < 2; p++) begin
            if (wb_we[p] && wb_addr[p] != '0) model_regs[wb_addr[p]] = wb_data[p];
        end
    endtask

    always begin
        @(negedge clk);
        #5;
        if (rst_n) model_cycle();
    end

    task automatic drive_lanes(input instr_t a, input logic va, input instr_t b,
                               input logic vb);
        {dec_pc[0], dec_op[0], dec_rdst[0], dec_ra1[0], dec_ra2[0], dec_imm[0]} = a;
        {dec_pc[1], dec_op[1], dec_rdst[1], dec_ra1[1], dec_ra2[1], dec_imm[1]} = b;
        dec_valid[0] = va;
        dec_valid[1] = vb;
        wb_we[0] = 1'b0;
        wb_we[1] = 1'b0;
    endtask

    task automatic set_writeback(input reg_t a0, input word_t d0, input reg_t a1,
                                 input word_t d1);
        wb_we[0]   = 1'b1;
        wb_addr[0] = a0;
        wb_data[0] = d0;
        wb_we[1]   = 1'b1;
        wb_addr[1] = a1;
        wb_data[1] = d1;
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            dec_valid[0] = 1'b0;
            dec_valid[1] = 1'b0;
            wb_we[0] = 1'b0;
            wb_we[1] = 1'b0;
        end
    endtask

    task automatic write_back(input reg_t a0, input word_t d0, input reg_t a1,
                              input word_t d1);
        idle(1);
        set_writeback(a0, d0, a1, d1);
    endtask

    // lanes stay on the bus until overflow lets them in
    task automatic send(input instr_t a, input logic va, input instr_t b, input logic vb);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            drive_lanes(a, va, b, vb);
            n++;
        end while (overflow && n < 200);
        if (overflow) begin
            $display("timeout: decode held back by overflow for 200 cycles");
            errors++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        do begin
            idle(1);
            n++;
        end while (exp_q.size() != 0 && n < 200);
        if (exp_q.size() != 0) begin
            $display("timeout: %0d instructions never issued", exp_q.size());
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            pass_count++;
            $display("%s: ok", name);
        end else begin
            fail_count++;
            $display("%s: %0d error(s)", name, errors - errs_before);
        end
    endtask

    task automatic dual_issue();
        int e;
        e = errors;
        write_back(5'd1, $random(seed), 5'd2, $random(seed));
        write_back(5'd3, $random(seed), 5'd4, $random(seed));
        send(mk(OP_ADD, 5'd5, 5'd1, 5'd2), 1'b1, mk(OP_SUB, 5'd6, 5'd3, 5'd4), 1'b1);
        wait_drain();
        end_test("dual issue", e);
    endtask

    task automatic hazard_split();
        int e;
        e = errors;
        send(mk(OP_ADD, 5'd7, 5'd1, 5'd2), 1'b1, mk(OP_SUB, 5'd8, 5'd7, 5'd3), 1'b1);
        wait_drain();
        send(mk(OP_MULT, 5'd0, 5'd1, 5'd2), 1'b1, mk(OP_DIV, 5'd0, 5'd3, 5'd4), 1'b1);
        wait_drain();
        send(mk(OP_MTLO, 5'd0, 5'd5, 5'd0), 1'b1, mk(OP_MFLO, 5'd9, 5'd0, 5'd0), 1'b1);
        wait_drain();
        end_test("hazard split", e);
    endtask

    task automatic branch_slot();
        int e;
        e = errors;
        send(mk(OP_BEQ, 5'd0, 5'd1, 5'd2), 1'b1, mk(OP_ADD, 5'd10, 5'd1, 5'd3), 1'b1);
        wait_drain();
        // lone branch sits in the queue until the slot shows up
        send(mk(OP_BNE, 5'd0, 5'd3, 5'd4), 1'b1, mk(OP_NOP, 5'd0, 5'd0, 5'd0), 1'b0);
        idle(4);
        send(mk(OP_OR, 5'd11, 5'd2, 5'd4), 1'b1, mk(OP_NOP, 5'd0, 5'd0, 5'd0), 1'b0);
        wait_drain();
        send(mk(OP_ADD, 5'd12, 5'd1, 5'd1), 1'b1, mk(OP_J, 5'd0, 5'd0, 5'd0), 1'b1);
        send(mk(OP_AND, 5'd13, 5'd2, 5'd3), 1'b1, mk(OP_LUI, 5'd14, 5'd0, 5'd0), 1'b1);
        wait_drain();
        // slot reading the link register still pairs
        send(mk(OP_JAL, 5'd31, 5'd0, 5'd0), 1'b1, mk(OP_ADD, 5'd15, 5'd31, 5'd1), 1'b1);
        wait_drain();
        end_test("branch slot", e);
    endtask

    task automatic writeback_forwarding();
        int e;
        e = errors;
        write_back(5'd5, 32'h1111_1111, 5'd6, 32'h2222_2222);
        send(mk(OP_ADD, 5'd16, 5'd5, 5'd6), 1'b1, mk(OP_OR, 5'd17, 5'd0, 5'd6), 1'b1);
        set_writeback(5'd5, 32'haaaa_0001, 5'd5, 32'hbbbb_0002);
        send(mk(OP_SUB, 5'd18, 5'd6, 5'd5), 1'b1, mk(OP_AND, 5'd19, 5'd0, 5'd0), 1'b1);
        set_writeback(5'd6, 32'hcccc_0003, 5'd0, 32'hdddd_0004);
        send(mk(OP_ADD, 5'd20, 5'd5, 5'd0), 1'b1, mk(OP_NOP, 5'd0, 5'd0, 5'd0), 1'b0);
        wait_drain();
        end_test("forwarding", e);
    endtask

    task automatic stall_overflow();
        int     e;
        int     n;
        instr_t a;
        instr_t b;
        e = errors;
        n = 0;
        stall = 1'b1;
        while (!overflow && n < 40) begin
            send(mk(OP_ADD, 5'(n % 8 + 8), 5'd1, 5'd2), 1'b1,
                 mk(OP_OR, 5'(n % 8 + 16), 5'd3, 5'd4), 1'b1);
            idle(1);
            n++;
        end
        if (!overflow) begin
            $display("overflow never rose while the queue filled under stall");
            errors++;
        end
        a = mk(OP_SUB, 5'd24, 5'd1, 5'd3);
        b = mk(OP_AND, 5'd25, 5'd2, 5'd4);
        repeat (3) begin
            @(negedge clk);
            drive_lanes(a, 1'b1, b, 1'b1);
        end
        stall = 1'b0;
        send(a, 1'b1, b, 1'b1);
        wait_drain();
        if (overflow !== 1'b0) report_mismatch("overflow", 32'h0, 32'(overflow));
        end_test("stall and overflow", e);
    endtask

    task automatic flush_recovery();
        int e;
        e = errors;
        stall = 1'b1;
        send(mk(OP_ADD, 5'd21, 5'd1, 5'd2), 1'b1, mk(OP_SUB, 5'd22, 5'd3, 5'd4), 1'b1);
        send(mk(OP_AND, 5'd23, 5'd1, 5'd3), 1'b1, mk(OP_OR, 5'd24, 5'd2, 5'd4), 1'b1);
        // decode during flush is dropped
        @(negedge clk);
        drive_lanes(mk(OP_ADD, 5'd25, 5'd1, 5'd1), 1'b1, mk(OP_OR, 5'd26, 5'd2, 5'd2), 1'b1);
        flush = 1'b1;
        stall = 1'b0;
        send(mk(OP_OR, 5'd27, 5'd5, 5'd6), 1'b1, mk(OP_ADD, 5'd28, 5'd1, 5'd2), 1'b1);
        flush = 1'b0;
        wait_drain();
        end_test("flush", e);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        seed = 32'h817c_1850;
        next_pc = 32'h0000_1000;
        errors = 0;
        pass_count = 0;
        fail_count = 0;
        drive_lanes('0, 1'b0, '0, 1'b0);
        for (int i = 0; i < 2; i++) begin
            wb_addr[i] = '0;
            wb_data[i] = '0;
        end
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        dual_issue();
        hazard_split();
        branch_slot();
        writeback_forwarding();
        stall_overflow();
        flush_recovery();
        idle(2);
        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_t;
    typedef logic [5:0]  op_t;

    localparam int NUM_REGS = 32;

    // decoded op codes
    localparam op_t OP_NOP  = 6'd0;
    localparam op_t OP_ADD  = 6'd1;
    localparam op_t OP_SUB  = 6'd2;
    localparam op_t OP_AND  = 6'd3;
    localparam op_t OP_OR   = 6'd4;
    localparam op_t OP_LUI  = 6'd5;
    localparam op_t OP_BEQ  = 6'd6;
    localparam op_t OP_BNE  = 6'd7;
    localparam op_t OP_J    = 6'd8;
    localparam op_t OP_JAL  = 6'd9;
    localparam op_t OP_MULT = 6'd10;
    localparam op_t OP_DIV  = 6'd11;
    localparam op_t OP_MFHI = 6'd12;
    localparam op_t OP_MFLO = 6'd13;
    localparam op_t OP_MTHI = 6'd14;
    localparam op_t OP_MTLO = 6'd15;

    function automatic logic is_branch(input op_t op);
        return op == OP_BEQ || op == OP_BNE || op == OP_J || op == OP_JAL;
    endfunction

    // jal writes the link register
    function automatic logic writes_reg(input op_t op);
        return op == OP_ADD || op == OP_SUB || op == OP_AND || op == OP_OR ||
               op == OP_LUI || op == OP_JAL || op == OP_MFHI || op == OP_MFLO;
    endfunction

    function automatic logic is_muldiv(input op_t op);
        return op == OP_MULT || op == OP_DIV;
    endfunction

    function automatic logic writes_hilo(input op_t op);
        return op == OP_MULT || op == OP_DIV || op == OP_MTHI || op == OP_MTLO;
    endfunction

    function automatic logic reads_hilo(input op_t op);
        return op == OP_MFHI || op == OP_MFLO;
    endfunction

endpackage

`default_nettype wire

/* src/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    localparam int QUEUE_DEPTH = 16;
    localparam int QUEUE_IDX_W = 4;

    // pc, op, rdst, ra1, ra2, imm
    localparam int ENTRY_W = 32 + 6 + 5 + 5 + 5 + 32;

    // free slots below this raise overflow
    localparam int QUEUE_MIN_FREE = 3;

    typedef logic [QUEUE_IDX_W-1:0] qidx_t;
    typedef logic [ENTRY_W-1:0]     entry_t;

endpackage

`default_nettype wire

/* src/issue_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_queue
    import isa_pkg::*;
    import issue_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  flush,
    input  logic  stall,
    input  logic  dec_valid  [2],
    input  word_t dec_pc     [2],
    input  op_t   dec_op     [2],
    input  reg_t  dec_rdst   [2],
    input  reg_t  dec_ra1    [2],
    input  reg_t  dec_ra2    [2],
    input  word_t dec_imm    [2],
    input  logic  issue_en   [2],
    output logic  cand_valid [2],
    output word_t cand_pc    [2],
    output op_t   cand_op    [2],
    output reg_t  cand_rdst  [2],
    output reg_t  cand_ra1   [2],
    output reg_t  cand_ra2   [2],
    output word_t cand_imm   [2],
    output logic  overflow
);

    entry_t mem [QUEUE_DEPTH];
    qidx_t  head;
    qidx_t  tail;
    logic [QUEUE_IDX_W:0] count;

    entry_t dec_entry  [2];
    entry_t cand_entry [2];
    logic   cand_vld   [2];
    logic   dec_iss    [2];
    logic   enq        [2];
    logic [1:0] n_pop;
    logic [1:0] n_enq;
    qidx_t  slot1;

    assign overflow = count > (QUEUE_IDX_W + 1)'(QUEUE_DEPTH - QUEUE_MIN_FREE);

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            dec_entry[i] = {dec_pc[i], dec_op[i], dec_rdst[i],
                            dec_ra1[i], dec_ra2[i], dec_imm[i]};
        end
    end

    // the two oldest, with decode filling in behind a short queue
    always_comb begin
        if (count == '0) begin
            cand_entry[0] = dec_entry[0];
            cand_entry[1] = dec_entry[1];
            cand_vld[0]   = dec_valid[0];
            cand_vld[1]   = dec_valid[1];
        end else if (count == 1) begin
            cand_entry[0] = mem[head];
            cand_entry[1] = dec_entry[0];
            cand_vld[0]   = 1'b1;
            cand_vld[1]   = dec_valid[0];
        end else begin
            cand_entry[0] = mem[head];
            cand_entry[1] = mem[qidx_t'(head + 1'b1)];
            cand_vld[0]   = 1'b1;
            cand_vld[1]   = 1'b1;
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            cand_valid[i] = cand_vld[i] & ~flush;
            {cand_pc[i], cand_op[i], cand_rdst[i],
             cand_ra1[i], cand_ra2[i], cand_imm[i]} = cand_entry[i];
        end
    end

    // split issued lanes into queue pops and direct decode issues
    always_comb begin
        dec_iss[0] = 1'b0;
        dec_iss[1] = 1'b0;
        n_pop      = 2'd0;
        if (count == '0) begin
            dec_iss[0] = issue_en[0];
            dec_iss[1] = issue_en[1];
        end else if (count == 1) begin
            dec_iss[0] = issue_en[1];
            n_pop      = {1'b0, issue_en[0]};
        end else begin
            n_pop = {1'b0, issue_en[0]} + {1'b0, issue_en[1]};
        end
    end

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            enq[i] = dec_valid[i] & ~dec_iss[i] & ~flush & ~overflow;
        end
        n_enq = {1'b0, enq[0]} + {1'b0, enq[1]};
        // lane 1 lands behind lane 0 only if lane 0 was queued too
        slot1 = enq[0] ? qidx_t'(tail + 1'b1) : tail;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= tail;
            count <= '0;
        end else begin
            head  <= head + n_pop;
            tail  <= tail + n_enq;
            count <= count + n_enq - n_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (enq[0]) begin
            mem[tail] <= dec_entry[0];
        end
        if (enq[1]) begin
            mem[slot1] <= dec_entry[1];
        end
    end

    occupancy_a: assert property (@(posedge clk) disable iff (!rst_n)
        count <= QUEUE_DEPTH)
        else $error("issue queue occupancy above depth");

    // back-pressure holds the tail for the whole cycle
    no_enq_on_overflow_a: assert property (@(posedge clk) disable iff (!rst_n)
        overflow |=> tail == $past(tail))
        else $error("enqueue while overflow");

    stall_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        stall && !flush |=> head == $past(head))
        else $error("head moved during stall");

endmodule

`default_nettype wire

/* src/issue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_top
    import isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  dec_valid  [2],
    input  word_t dec_pc     [2],
    input  op_t   dec_op     [2],
    input  reg_t  dec_rdst   [2],
    input  reg_t  dec_ra1    [2],
    input  reg_t  dec_ra2    [2],
    input  word_t dec_imm    [2],
    input  logic  wb_we      [2],
    input  reg_t  wb_addr    [2],
    input  word_t wb_data    [2],
    input  logic  stall,
    input  logic  flush,
    output logic  iss_valid  [2],
    output word_t iss_pc     [2],
    output op_t   iss_op     [2],
    output reg_t  iss_rdst   [2],
    output word_t iss_rs_val [2],
    output word_t iss_rt_val [2],
    output word_t iss_imm    [2],
    output logic  iss_slot   [2],
    output logic  overflow
);

    logic  cand_valid [2];
    word_t cand_pc    [2];
    op_t   cand_op    [2];
    reg_t  cand_rdst  [2];
    reg_t  cand_ra1   [2];
    reg_t  cand_ra2   [2];
    word_t cand_imm   [2];
    logic  issue_en   [2];
    logic  slot_mark;
    reg_t  rf_raddr   [4];
    word_t rf_rdata   [4];
    word_t operand    [4];

    issue_queue u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (flush),
        .stall      (stall),
        .dec_valid  (dec_valid),
        .dec_pc     (dec_pc),
        .dec_op     (dec_op),
        .dec_rdst   (dec_rdst),
        .dec_ra1    (dec_ra1),
        .dec_ra2    (dec_ra2),
        .dec_imm    (dec_imm),
        .issue_en   (issue_en),
        .cand_valid (cand_valid),
        .cand_pc    (cand_pc),
        .cand_op    (cand_op),
        .cand_rdst  (cand_rdst),
        .cand_ra1   (cand_ra1),
        .cand_ra2   (cand_ra2),
        .cand_imm   (cand_imm),
        .overflow   (overflow)
    );

    pair_check u_pair (
        .stall      (stall),
        .cand_valid (cand_valid),
        .cand_op    (cand_op),
        .cand_rdst  (cand_rdst),
        .cand_ra1   (cand_ra1),
        .cand_ra2   (cand_ra2),
        .issue_en   (issue_en),
        .slot_mark  (slot_mark)
    );

    // read ports 0/1 for lane 0, 2/3 for lane 1
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            rf_raddr[2*i]   = cand_ra1[i];
            rf_raddr[2*i+1] = cand_ra2[i];
        end
    end

    reg_file u_rf (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (rf_raddr),
        .rdata (rf_rdata),
        .we    (wb_we),
        .waddr (wb_addr),
        .wdata (wb_data)
    );

    operand_select u_opsel (
        .raddr   (rf_raddr),
        .rdata   (rf_rdata),
        .wb_we   (wb_we),
        .wb_addr (wb_addr),
        .wb_data (wb_data),
        .operand (operand)
    );

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            iss_valid[i]  = cand_valid[i] & issue_en[i];
            iss_pc[i]     = cand_pc[i];
            iss_op[i]     = cand_op[i];
            iss_rdst[i]   = cand_rdst[i];
            iss_imm[i]    = cand_imm[i];
            iss_rs_val[i] = operand[2*i];
            iss_rt_val[i] = operand[2*i+1];
        end
        // only the younger lane can be a delay slot
        iss_slot[0] = 1'b0;
        iss_slot[1] = slot_mark;
    end

endmodule

`default_nettype wire

/* src/operand_select.sv */
`timescale 1ns/1ps
`default_nettype none

module operand_select
    import isa_pkg::*;
(
    input  reg_t  raddr   [4],
    input  word_t rdata   [4],
    input  logic  wb_we   [2],
    input  reg_t  wb_addr [2],
    input  word_t wb_data [2],
    output word_t operand [4]
);

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            operand[i] = rdata[i];
            // lane 1 checked last so it takes priority
            for (int w = 0; w < 2; w++) begin
                if (wb_we[w] && wb_addr[w] == raddr[i] && raddr[i] != '0) begin
                    operand[i] = wb_data[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/pair_check.sv */
`timescale 1ns/1ps
`default_nettype none

module pair_check
    import isa_pkg::*;
(
    input  logic stall,
    input  logic cand_valid [2],
    input  op_t  cand_op    [2],
    input  reg_t cand_rdst  [2],
    input  reg_t cand_ra1   [2],
    input  reg_t cand_ra2   [2],
    output logic issue_en   [2],
    output logic slot_mark
);

    logic br0;
    logic raw_hazard;
    logic muldiv_pair;
    logic hilo_hazard;
    logic lane1_ok;

    assign br0 = is_branch(cand_op[0]);

    // a delay slot may read the link register written by jal
    assign raw_hazard = writes_reg(cand_op[0]) && cand_rdst[0] != '0 && !br0 &&
                        (cand_rdst[0] == cand_ra1[1] || cand_rdst[0] == cand_ra2[1]);

    assign muldiv_pair = is_muldiv(cand_op[0]) && is_muldiv(cand_op[1]);
    assign hilo_hazard = writes_hilo(cand_op[0]) && reads_hilo(cand_op[1]);

    assign lane1_ok = cand_valid[1] && !is_branch(cand_op[1]) &&
                      !raw_hazard && !muldiv_pair && !hilo_hazard;

    // branch waits until its slot can go along
    assign issue_en[0] = cand_valid[0] && !stall && (!br0 || lane1_ok);
    assign issue_en[1] = issue_en[0] && lane1_ok;
    assign slot_mark   = br0 && issue_en[1];

endmodule

`default_nettype wire

/* src/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import isa_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  reg_t  raddr [4],
    output word_t rdata [4],
    input  logic  we    [2],
    input  reg_t  waddr [2],
    input  word_t wdata [2]
);

    word_t regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // port 1 written last, wins on a clash
            for (int p = 0; p < 2; p++) begin
                if (we[p] && waddr[p] != '0) begin
                    regs[waddr[p]] <= wdata[p];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            rdata[i] = (raddr[i] == '0) ? '0 : regs[raddr[i]];
        end
    end

    zero_reg_a: assert property (@(posedge clk) disable iff (!rst_n)
        (we[0] && waddr[0] == '0) || (we[1] && waddr[1] == '0) |=> regs[0] == '0)
        else $error("register 0 modified");

endmodule

`default_nettype wire
